//--- bench/pmr_cases.txt
// columns: channel, drop flag, first page pointer, length in bytes
// all values hex, one request per line
1 0 05 0040
2 0 0a 0051
3 1 11 0030
0 0 3f 0003
1 0 20 00c8
2 1 07 0100
3 0 2c 0008
0 0 00 0079
1 0 33 0047
2 0 15 0011

//--- bench/pmr_tb.sv
`timescale 1ns/1ps
`include "pmr_cfg.svh"

module pmr_tb;

    logic                             clk = 1'b0;
    logic                             rst = 1'b1;
    logic                             pkt_req_vld = 1'b0;
    logic                             pkt_req_rdy;
    pmr_ctrl_pkg::page_ptr_t          pkt_req_ptr = '0;
    pmr_msg_pkg::pkt_len_t            pkt_req_len = '0;
    pmr_msg_pkg::chn_id_t             pkt_req_chn = '0;
    logic                             pkt_req_drop = 1'b0;
    logic                             link_ram_ren;
    pmr_ctrl_pkg::page_ptr_t          link_ram_raddr;
    pmr_ctrl_pkg::page_ptr_t          link_ram_rdata = '0;
    logic                             cell_ram_ren;
    logic [`PMR_PTR_W+`PMR_IDX_W-1:0] cell_ram_raddr;
    pmr_msg_pkg::cell_data_t          cell_ram_rdata = '0;
    logic                             out_cell_vld;
    logic                             out_cell_rdy = 1'b0;
    pmr_msg_pkg::cell_data_t          out_cell_dat;
    logic                             out_cell_sop;
    logic                             out_cell_eop;
    logic                             out_cell_soc;
    logic                             out_cell_eoc;
    pmr_msg_pkg::mty_t                out_cell_mty;
    pmr_msg_pkg::chn_id_t             out_cell_chn;

    logic [15:0]             case_mem [0:63]; // chn, drop, ptr, len per case.
    int                      num_cases;
    int                      cycle_limit;
    int                      cycle_cnt;
    int                      error_cnt;
    int                      check_cnt;
    int                      seen_cells;
    int                      case_base;
    int                      exp_len;
    int                      exp_cells;
    pmr_ctrl_pkg::page_ptr_t exp_ptr;
    pmr_msg_pkg::chn_id_t    exp_chn;
    logic [31:0]             lfsr;
    logic                    rdy_prev;
    logic                    req_rdy_s;

    pmr_top i_pmr_top (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // successor page in the link RAM model.
    function automatic pmr_ctrl_pkg::page_ptr_t link_of(input pmr_ctrl_pkg::page_ptr_t p);
        return pmr_ctrl_pkg::page_ptr_t'((int'(p) * 5 + 3) % 64);
    endfunction

    // full cell address repeated in each 16-bit lane.
    function automatic pmr_msg_pkg::cell_data_t cell_fill(
        input logic [`PMR_PTR_W+`PMR_IDX_W-1:0] a);
        return {4{16'(a)}};
    endfunction

    always @(posedge clk)
    begin
        if (link_ram_ren)
            link_ram_rdata <= link_of(link_ram_raddr);
        if (cell_ram_ren)
            cell_ram_rdata <= cell_fill(cell_ram_raddr);
    end

    task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            error_cnt++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // one clock edge with the output cell checked against the model.
    task automatic tick();
        int                      k;
        int                      p;
        int                      exp_mty;
        logic                    last;
        pmr_ctrl_pkg::page_ptr_t page;
        @(posedge clk);
        req_rdy_s = pkt_req_rdy;
        if (!rst && out_cell_vld)
        begin
            k = seen_cells - case_base;
            if (!rdy_prev)
            begin
                error_cnt++;
                $display("cell at %0t follows a cycle without out_cell_rdy", $time);
            end
            if (k >= exp_cells)
            begin
                error_cnt++;
                $display("unexpected cell at %0t beyond the packet length", $time);
            end
            else
            begin
                page = exp_ptr;
                for (p = 0; p < k / 8; p++)
                    page = link_of(page);
                last = (k == exp_cells - 1);
                exp_mty = (last && (exp_len % 8 != 0)) ? 8 - exp_len % 8 : 0;
                check_value("out_cell_dat", out_cell_dat,
                    cell_fill({page, pmr_ctrl_pkg::cell_idx_t'(k % 8)}));
                check_value("out_cell_sop", 64'(out_cell_sop), 64'(k == 0));
                check_value("out_cell_eop", 64'(out_cell_eop), 64'(last));
                check_value("out_cell_mty", 64'(out_cell_mty), 64'(exp_mty));
                check_value("out_cell_soc", 64'(out_cell_soc), 64'(k % 8 == 0));
                check_value("out_cell_eoc", 64'(out_cell_eoc), 64'(k % 8 == 7 || last));
                check_value("out_cell_chn", 64'(out_cell_chn), 64'(exp_chn));
            end
            seen_cells++;
        end
        rdy_prev = out_cell_rdy;
        lfsr = lfsr_next(lfsr);
        out_cell_rdy <= lfsr[0]; // random read credit.
    endtask

    initial
    begin
        int c;
        int errs_before;
        int total_cells;
        error_cnt = 0;
        check_cnt = 0;
        seen_cells = 0;
        case_base = 0;
        exp_cells = 0;
        exp_len = 0;
        exp_ptr = '0;
        exp_chn = '0;
        rdy_prev = 1'b0;
        req_rdy_s = 1'b0;
        lfsr = 32'h1104_d94b;
        for (c = 0; c < 64; c++)
            case_mem[c] = 16'hffff;
        $readmemh("bench/pmr_cases.txt", case_mem);
        num_cases = 0;
        total_cells = 0;
        while (num_cases < 16 && case_mem[4 * num_cases] != 16'hffff)
        begin
            total_cells += (int'(case_mem[4 * num_cases + 3]) + 7) / 8;
            num_cases++;
        end
        cycle_limit = total_cells * 4 + 200;
        if (num_cases == 0)
        begin
            error_cnt++;
            $display("no requests were read from bench/pmr_cases.txt");
        end

        repeat (8) tick();
        rst <= 1'b0;
        tick();
        check_value("pkt_req_rdy", 64'(req_rdy_s), 64'(1));
        check_value("out_cell_vld", 64'(out_cell_vld), 64'(0));

        for (c = 0; c < num_cases; c++)
        begin
            exp_ptr = pmr_ctrl_pkg::page_ptr_t'(case_mem[4 * c + 2]);
            exp_len = int'(case_mem[4 * c + 3]);
            exp_chn = pmr_msg_pkg::chn_id_t'(case_mem[4 * c]);
            exp_cells = (case_mem[4 * c + 1] != 16'h0) ? 0 : (exp_len + 7) / 8; // none when dropped.
            case_base = seen_cells;
            errs_before = error_cnt;
            pkt_req_vld <= 1'b1;
            pkt_req_ptr <= exp_ptr;
            pkt_req_len <= pmr_msg_pkg::pkt_len_t'(case_mem[4 * c + 3]);
            pkt_req_chn <= exp_chn;
            pkt_req_drop <= (case_mem[4 * c + 1] != 16'h0);
            do tick(); while (!req_rdy_s);
            pkt_req_vld <= 1'b0;
            do tick(); while (!req_rdy_s); // back in idle after the last read.
            check_value("cell count", 64'(seen_cells - case_base), 64'(exp_cells));
            $display("case %0d chn %0d drop %0d ptr %0h len %0d cells %0d: %s", c, exp_chn,
                case_mem[4 * c + 1], exp_ptr, exp_len, exp_cells,
                (error_cnt == errs_before) ? "ok" : "errors");
        end

        $display("cases %0d, checks %0d, errors %0d", num_cases, check_cnt, error_cnt);
        if (error_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the engine stopped finishing packets", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/pmr_msg_pkg.sv
source/pmr_ctrl_pkg.sv
source/pmr_read_fsm.sv
source/pmr_length_counter.sv
source/pmr_page_chain.sv
source/pmr_cell_output.sv
source/pmr_top.sv
bench/pmr_tb.sv

//--- sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pmr_tb -f build.f -o pmr_sim || exit 1
sim_out=$(./obj_dir/pmr_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation completed successfully" && exit 0 || exit 1

//--- source/pmr_cell_output.sv
`timescale 1ns/1ps
`include "pmr_cfg.svh"

module pmr_cell_output
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    take,
    input  pmr_msg_pkg::chn_id_t    pkt_req_chn,
    input  logic                    pkt_req_drop,
    input  logic                    cell_ren,
    input  logic                    last_cell,
    input  logic                    page_end,
    input  pmr_ctrl_pkg::cell_idx_t cell_idx,
    input  pmr_msg_pkg::pkt_len_t   rem_len,
    input  pmr_msg_pkg::cell_data_t cell_ram_rdata,
    output logic                    out_cell_vld,
    output pmr_msg_pkg::cell_data_t out_cell_dat,
    output logic                    out_cell_sop,
    output logic                    out_cell_eop,
    output logic                    out_cell_soc,
    output logic                    out_cell_eoc,
    output pmr_msg_pkg::mty_t       out_cell_mty,
    output pmr_msg_pkg::chn_id_t    out_cell_chn
);

    pmr_msg_pkg::chn_id_t  chn_q;
    logic                  drop_q;
    logic                  first_rd;
    logic                  emit;
    logic                  short_cell;
    pmr_msg_pkg::pkt_len_t pad_len;

    assign emit       = cell_ren && !drop_q; // dropped packets are read but not shown.
    assign short_cell = (rem_len < pmr_msg_pkg::pkt_len_t'(`PMR_CELL_BYTES));
    assign pad_len    = pmr_msg_pkg::pkt_len_t'(`PMR_CELL_BYTES) - rem_len;

    // RAM latency lines data up with the registered tags.
    assign out_cell_dat = cell_ram_rdata;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            chn_q        <= '0;
            drop_q       <= 1'b0;
            first_rd     <= 1'b0;
            out_cell_vld <= 1'b0;
            out_cell_sop <= 1'b0;
            out_cell_eop <= 1'b0;
            out_cell_soc <= 1'b0;
            out_cell_eoc <= 1'b0;
            out_cell_mty <= '0;
            out_cell_chn <= '0;
        end
        else
        begin
            if (take)
            begin
                chn_q  <= pkt_req_chn;
                drop_q <= pkt_req_drop;
            end
            if (take)
                first_rd <= 1'b1;
            else if (cell_ren)
                first_rd <= 1'b0;

            out_cell_vld <= emit;
            out_cell_sop <= emit && first_rd;
            out_cell_eop <= emit && last_cell;
            out_cell_soc <= emit && (cell_idx == '0);
            out_cell_eoc <= emit && (page_end || last_cell);
            out_cell_mty <= (emit && last_cell && short_cell) ? pad_len[`PMR_MTY_W-1:0] : '0;
            out_cell_chn <= chn_q;
        end
    end

endmodule

//--- source/pmr_cfg.svh
`ifndef PMR_CFG_SVH
`define PMR_CFG_SVH

// bytes carried by one cell.
`define PMR_CELL_BYTES 8

// cell data width, 8 bits per byte.
`define PMR_DATA_W 64

// page pointer width, 64 pages in the buffer.
`define PMR_PTR_W 6

// cell index within a page, so 8 cells per page.
`define PMR_IDX_W 3

// packet length in bytes.
`define PMR_LEN_W 16

// channel number width.
`define PMR_CHN_W 2

// empty byte count in the last cell.
`define PMR_MTY_W 3

`endif

//--- source/pmr_ctrl_pkg.sv
`include "pmr_cfg.svh"

// engine control types.
package pmr_ctrl_pkg;

    typedef logic [`PMR_PTR_W-1:0] page_ptr_t;

    typedef logic [`PMR_IDX_W-1:0] cell_idx_t;

    // LINK fetches the successor of the current page.
    typedef enum logic [1:0]
    {
        IDLE,
        LINK,
        READ
    } rd_state_t;

endpackage

//--- source/pmr_length_counter.sv
`timescale 1ns/1ps
`include "pmr_cfg.svh"

module pmr_length_counter
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   take,
    input  pmr_msg_pkg::pkt_len_t  pkt_req_len,
    input  logic                   link_ren,
    input  logic                   cell_ren,
    output pmr_msg_pkg::pkt_len_t  rem_len,
    output pmr_ctrl_pkg::cell_idx_t cell_idx,
    output logic                   last_cell,
    output logic                   page_end
);

    assign last_cell = (rem_len <= pmr_msg_pkg::pkt_len_t'(`PMR_CELL_BYTES));
    assign page_end  = &cell_idx;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rem_len  <= '0;
            cell_idx <= '0;
        end
        else
        begin
            if (take)
                rem_len <= pkt_req_len;
            else if (cell_ren && last_cell)
                rem_len <= '0; // short tail cell.
            else if (cell_ren)
                rem_len <= rem_len - pmr_msg_pkg::pkt_len_t'(`PMR_CELL_BYTES);

            // index restarts with every page fetch.
            if (link_ren)
                cell_idx <= '0;
            else if (cell_ren)
                cell_idx <= cell_idx + 1'b1;
        end
    end

    // the FSM must leave READ once the length runs out.
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        cell_ren |-> (rem_len != '0));

endmodule

//--- source/pmr_msg_pkg.sv
`include "pmr_cfg.svh"

// request and cell message fields.
package pmr_msg_pkg;

    // one cell of packet data.
    typedef logic [`PMR_DATA_W-1:0] cell_data_t;

    // packet length in bytes.
    typedef logic [`PMR_LEN_W-1:0] pkt_len_t;

    // channel tag.
    typedef logic [`PMR_CHN_W-1:0] chn_id_t;

    // empty bytes at the tail of the last cell.
    typedef logic [`PMR_MTY_W-1:0] mty_t;

endpackage

//--- source/pmr_page_chain.sv
`timescale 1ns/1ps
`include "pmr_cfg.svh"

module pmr_page_chain
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  take,
    input  pmr_ctrl_pkg::page_ptr_t               pkt_req_ptr,
    input  logic                                  link_ren,
    output pmr_ctrl_pkg::page_ptr_t               link_ram_raddr,
    input  pmr_ctrl_pkg::page_ptr_t               link_ram_rdata,
    input  pmr_ctrl_pkg::cell_idx_t               cell_idx,
    output logic [`PMR_PTR_W+`PMR_IDX_W-1:0]      cell_ram_raddr
);

    pmr_ctrl_pkg::page_ptr_t cur_page;
    pmr_ctrl_pkg::page_ptr_t next_page;
    logic                    first_link; // no successor fetched yet.
    logic                    link_rd_q;

    // the first fetch reads the head page's own link.
    assign link_ram_raddr = first_link ? cur_page : next_page;
    assign cell_ram_raddr = {cur_page, cell_idx};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            first_link <= 1'b0;
            link_rd_q  <= 1'b0;
        end
        else
        begin
            link_rd_q <= link_ren;
            if (take)
                first_link <= 1'b1;
            else if (link_ren)
                first_link <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
            cur_page <= pkt_req_ptr;
        else if (link_ren)
            cur_page <= link_ram_raddr; // step onto the fetched page.

        if (link_rd_q)
            next_page <= link_ram_rdata;
    end

endmodule

//--- source/pmr_read_fsm.sv
`timescale 1ns/1ps
`include "pmr_cfg.svh"

module pmr_read_fsm
(
    input  logic clk,
    input  logic rst,
    input  logic pkt_req_vld,
    output logic pkt_req_rdy,
    input  logic out_cell_rdy,
    input  logic last_cell,
    input  logic page_end,
    output logic take,
    output logic link_ren,
    output logic cell_ren
);

    pmr_ctrl_pkg::rd_state_t state;
    pmr_ctrl_pkg::rd_state_t state_nxt;

    assign pkt_req_rdy = (state == pmr_ctrl_pkg::IDLE);
    assign take        = pkt_req_vld && pkt_req_rdy;
    assign link_ren    = (state == pmr_ctrl_pkg::LINK);
    assign cell_ren    = (state == pmr_ctrl_pkg::READ) && out_cell_rdy; // one cell per credit.

    always_comb
    begin
        state_nxt = state;
        case (state)
            pmr_ctrl_pkg::IDLE:
            begin
                if (take)
                    state_nxt = pmr_ctrl_pkg::LINK;
            end
            pmr_ctrl_pkg::LINK:
                state_nxt = pmr_ctrl_pkg::READ;
            pmr_ctrl_pkg::READ:
            begin
                if (cell_ren && last_cell)
                    state_nxt = pmr_ctrl_pkg::IDLE;
                else if (cell_ren && page_end)
                    state_nxt = pmr_ctrl_pkg::LINK; // walk to the next page.
            end
            default:
                state_nxt = pmr_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= pmr_ctrl_pkg::IDLE;
        else
            state <= state_nxt;
    end

    // a fresh page never starts at its last cell.
    a_page_start_after_link: assert property (@(posedge clk) disable iff (rst)
        link_ren |=> !page_end);

endmodule

//--- source/pmr_top.sv
`timescale 1ns/1ps
`include "pmr_cfg.svh"

module pmr_top
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pkt_req_vld,
    output logic                               pkt_req_rdy,
    input  pmr_ctrl_pkg::page_ptr_t            pkt_req_ptr,
    input  pmr_msg_pkg::pkt_len_t              pkt_req_len,
    input  pmr_msg_pkg::chn_id_t               pkt_req_chn,
    input  logic                               pkt_req_drop,
    output logic                               link_ram_ren,
    output pmr_ctrl_pkg::page_ptr_t            link_ram_raddr,
    input  pmr_ctrl_pkg::page_ptr_t            link_ram_rdata,
    output logic                               cell_ram_ren,
    output logic [`PMR_PTR_W+`PMR_IDX_W-1:0]   cell_ram_raddr,
    input  pmr_msg_pkg::cell_data_t            cell_ram_rdata,
    output logic                               out_cell_vld,
    input  logic                               out_cell_rdy,
    output pmr_msg_pkg::cell_data_t            out_cell_dat,
    output logic                               out_cell_sop,
    output logic                               out_cell_eop,
    output logic                               out_cell_soc,
    output logic                               out_cell_eoc,
    output pmr_msg_pkg::mty_t                  out_cell_mty,
    output pmr_msg_pkg::chn_id_t               out_cell_chn
);

    logic                    take;
    logic                    last_cell;
    logic                    page_end;
    pmr_msg_pkg::pkt_len_t   rem_len;
    pmr_ctrl_pkg::cell_idx_t cell_idx;

    // RAM strobes come straight from the FSM.
    pmr_read_fsm i_pmr_read_fsm
    (
        .clk          (clk),
        .rst          (rst),
        .pkt_req_vld  (pkt_req_vld),
        .pkt_req_rdy  (pkt_req_rdy),
        .out_cell_rdy (out_cell_rdy),
        .last_cell    (last_cell),
        .page_end     (page_end),
        .take         (take),
        .link_ren     (link_ram_ren),
        .cell_ren     (cell_ram_ren)
    );

    pmr_length_counter i_pmr_length_counter
    (
        .clk         (clk),
        .rst         (rst),
        .take        (take),
        .pkt_req_len (pkt_req_len),
        .link_ren    (link_ram_ren),
        .cell_ren    (cell_ram_ren),
        .rem_len     (rem_len),
        .cell_idx    (cell_idx),
        .last_cell   (last_cell),
        .page_end    (page_end)
    );

    pmr_page_chain i_pmr_page_chain
    (
        .clk            (clk),
        .rst            (rst),
        .take           (take),
        .pkt_req_ptr    (pkt_req_ptr),
        .link_ren       (link_ram_ren),
        .link_ram_raddr (link_ram_raddr),
        .link_ram_rdata (link_ram_rdata),
        .cell_idx       (cell_idx),
        .cell_ram_raddr (cell_ram_raddr)
    );

    pmr_cell_output i_pmr_cell_output
    (
        .clk            (clk),
        .rst            (rst),
        .take           (take),
        .pkt_req_chn    (pkt_req_chn),
        .pkt_req_drop   (pkt_req_drop),
        .cell_ren       (cell_ram_ren),
        .last_cell      (last_cell),
        .page_end       (page_end),
        .cell_idx       (cell_idx),
        .rem_len        (rem_len),
        .cell_ram_rdata (cell_ram_rdata),
        .out_cell_vld   (out_cell_vld),
        .out_cell_dat   (out_cell_dat),
        .out_cell_sop   (out_cell_sop),
        .out_cell_eop   (out_cell_eop),
        .out_cell_soc   (out_cell_soc),
        .out_cell_eoc   (out_cell_eoc),
        .out_cell_mty   (out_cell_mty),
        .out_cell_chn   (out_cell_chn)
    );

endmodule
